/* src/rv_fcvt_pkg.sv */
`default_nettype none

package rv_fcvt_pkg;

  //////////////////////////////////////////////////////////////////////
  // format codes
  //////////////////////////////////////////////////////////////////////

  // FCVT fmt field encoding
  typedef logic [1:0] fmt_t;

  localparam fmt_t FMT_SINGLE = 2'b00;
  localparam fmt_t FMT_DOUBLE = 2'b01;
  localparam fmt_t FMT_HALF   = 2'b10;
  localparam fmt_t FMT_QUAD   = 2'b11;

  //////////////////////////////////////////////////////////////////////
  // datapath vectors
  //////////////////////////////////////////////////////////////////////

  // operand or result, always quad wide inside the datapath
  typedef logic [127:0] fp_word_t;

  // unbiased exponent, room for rebias and rounding carry
  typedef logic signed [17:0] exp_wide_t;

  // hidden bit at [112], fraction left aligned below it
  typedef logic [112:0] man_wide_t;

  // riscv fflags order is nv dz of uf nx
  typedef logic [4:0] fflags_t;

  localparam int FLAG_NV = 4;
  localparam int FLAG_DZ = 3;
  localparam int FLAG_OF = 2;
  localparam int FLAG_UF = 1;
  localparam int FLAG_NX = 0;

  //////////////////////////////////////////////////////////////////////
  // per format constants, indexed by fmt_t
  //////////////////////////////////////////////////////////////////////

  // single, double, half, quad
  localparam int EXP_BITS [4] = '{8, 11, 5, 15};
  localparam int MAN_BITS [4] = '{23, 52, 10, 112};
  localparam int BIAS     [4] = '{127, 1023, 15, 16383};

endpackage

`default_nettype wire

/* src/fp_unpacked_if.sv */
`default_nettype none

// one operand, format independent
interface fp_unpacked_if;

  logic                   sign;
  // unbiased exponent
  rv_fcvt_pkg::exp_wide_t exp;
  // hidden bit included
  rv_fcvt_pkg::man_wide_t man;
  // zero or flushed subnormal
  logic                   is_zero;
  logic                   is_inf;
  logic                   is_nan;
  // nan with quiet bit clear
  logic                   is_snan;

  modport producer (
    output sign, exp, man, is_zero, is_inf, is_nan, is_snan
  );

  modport consumer (
    input sign, exp, man, is_zero, is_inf, is_nan, is_snan
  );

endinterface

`default_nettype wire

/* src/fp_unpack.sv */
`default_nettype none

module fp_unpack (
  input  rv_fcvt_pkg::fp_word_t data_i,
  input  rv_fcvt_pkg::fmt_t     ip_fmt_i,
  fp_unpacked_if.producer       unp
);

  // raw fields, right aligned
  logic         sign;
  logic [14:0]  exp_field;
  logic [111:0] frac_field;

  // fraction moved up to the quad position
  logic [111:0] frac_aligned;

  // all ones exponent of the source format
  logic [14:0]  exp_ones;

  logic         exp_is_ones;
  logic         exp_is_zero;
  logic         frac_is_zero;

  // field extraction per source format
  always_comb begin
    sign       = 1'b0;
    exp_field  = '0;
    frac_field = '0;
    case (ip_fmt_i)
      rv_fcvt_pkg::FMT_SINGLE: begin
        sign       = data_i[31];
        exp_field  = 15'(data_i[30:23]);
        frac_field = 112'(data_i[22:0]);
      end
      rv_fcvt_pkg::FMT_DOUBLE: begin
        sign       = data_i[63];
        exp_field  = 15'(data_i[62:52]);
        frac_field = 112'(data_i[51:0]);
      end
      rv_fcvt_pkg::FMT_HALF: begin
        sign       = data_i[15];
        exp_field  = 15'(data_i[14:10]);
        frac_field = 112'(data_i[9:0]);
      end
      default: begin
        sign       = data_i[127];
        exp_field  = data_i[126:112];
        frac_field = data_i[111:0];
      end
    endcase
  end

  assign exp_ones     = 15'((1 << rv_fcvt_pkg::EXP_BITS[ip_fmt_i]) - 1);
  assign exp_is_ones  = (exp_field == exp_ones);
  // subnormals land here too and get flushed
  assign exp_is_zero  = (exp_field == '0);
  assign frac_is_zero = (frac_field == '0);

  // left align so the fraction msb sits at [111]
  assign frac_aligned = frac_field << (112 - rv_fcvt_pkg::MAN_BITS[ip_fmt_i]);

  // classification
  assign unp.sign    = sign;
  assign unp.is_zero = exp_is_zero;
  assign unp.is_inf  = exp_is_ones & frac_is_zero;
  assign unp.is_nan  = exp_is_ones & ~frac_is_zero;
  // quiet bit is the fraction msb
  assign unp.is_snan = exp_is_ones & ~frac_is_zero & ~frac_aligned[111];

  // remove source bias
  assign unp.exp = rv_fcvt_pkg::exp_wide_t'({3'b000, exp_field})
                 - rv_fcvt_pkg::exp_wide_t'(rv_fcvt_pkg::BIAS[ip_fmt_i]);

  // restore hidden bit, zero carries no mantissa
  assign unp.man = exp_is_zero ? '0 : {1'b1, frac_aligned};

endmodule

`default_nettype wire

/* src/fp_pack_round.sv */
`default_nettype none

module fp_pack_round (
  fp_unpacked_if.consumer         unp,
  input  rv_fcvt_pkg::fmt_t       op_fmt_i,
  output rv_fcvt_pkg::fp_word_t   data_o,
  output rv_fcvt_pkg::fflags_t    fflags_o
);

  // target mantissa width
  int unsigned                man_bits;

  // kept fraction, right aligned
  logic [111:0]               frac_keep;
  // dropped bits, left aligned
  logic [111:0]               frac_drop;
  logic [111:0]               frac_mask;
  logic [111:0]               frac_out;
  logic [111:0]               qnan_frac;

  logic                       guard;
  logic                       sticky;
  logic                       round_up;
  logic                       carry;
  logic                       inexact;

  rv_fcvt_pkg::exp_wide_t     exp_biased;
  rv_fcvt_pkg::exp_wide_t     exp_max;
  logic                       overflow;
  logic                       underflow;

  // join sign, exponent and fraction for the target format
  function automatic rv_fcvt_pkg::fp_word_t pack_fields(
    input logic              s,
    input logic [14:0]       e,
    input logic [111:0]      f,
    input rv_fcvt_pkg::fmt_t fmt
  );
    pack_fields = (rv_fcvt_pkg::fp_word_t'(s)
                    << (rv_fcvt_pkg::EXP_BITS[fmt] + rv_fcvt_pkg::MAN_BITS[fmt]))
                | (rv_fcvt_pkg::fp_word_t'(e) << rv_fcvt_pkg::MAN_BITS[fmt])
                | rv_fcvt_pkg::fp_word_t'(f);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // round to nearest even
  //////////////////////////////////////////////////////////////////////

  assign man_bits  = rv_fcvt_pkg::MAN_BITS[op_fmt_i];
  // wraps to all ones for quad
  assign frac_mask = (112'(1) << man_bits) - 112'(1);

  assign frac_keep = unp.man[111:0] >> (112 - man_bits);
  assign frac_drop = unp.man[111:0] << man_bits;

  assign guard    = frac_drop[111];
  assign sticky   = |frac_drop[110:0];
  // ties go to the even neighbour
  assign round_up = guard & (sticky | frac_keep[0]);
  assign inexact  = guard | sticky;

  // 1.11..1 + ulp rolls over into the exponent
  assign carry    = round_up & (frac_keep == frac_mask);
  assign frac_out = (frac_keep + 112'(round_up)) & frac_mask;

  //////////////////////////////////////////////////////////////////////
  // rebias and range check
  //////////////////////////////////////////////////////////////////////

  assign exp_max = rv_fcvt_pkg::exp_wide_t'((1 << rv_fcvt_pkg::EXP_BITS[op_fmt_i]) - 1);

  assign exp_biased = unp.exp
                    + rv_fcvt_pkg::exp_wide_t'(rv_fcvt_pkg::BIAS[op_fmt_i])
                    + rv_fcvt_pkg::exp_wide_t'({17'd0, carry});

  // all ones or above saturates to infinity
  assign overflow  = (exp_biased >= exp_max);
  // no subnormal results, flush instead
  assign underflow = (exp_biased <= 0);

  // canonical nan has only the fraction msb set
  assign qnan_frac = 112'(1) << (man_bits - 1);

  //////////////////////////////////////////////////////////////////////
  // result select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    fflags_o = '0;
    if (unp.is_nan) begin
      data_o = pack_fields(1'b0, exp_max[14:0], qnan_frac, op_fmt_i);
      fflags_o[rv_fcvt_pkg::FLAG_NV] = unp.is_snan;
    end else if (unp.is_inf) begin
      data_o = pack_fields(unp.sign, exp_max[14:0], '0, op_fmt_i);
    end else if (unp.is_zero) begin
      data_o = pack_fields(unp.sign, '0, '0, op_fmt_i);
    end else if (overflow) begin
      // signed infinity
      data_o = pack_fields(unp.sign, exp_max[14:0], '0, op_fmt_i);
      fflags_o[rv_fcvt_pkg::FLAG_OF] = 1'b1;
      fflags_o[rv_fcvt_pkg::FLAG_NX] = 1'b1;
    end else if (underflow) begin
      // signed zero
      data_o = pack_fields(unp.sign, '0, '0, op_fmt_i);
      fflags_o[rv_fcvt_pkg::FLAG_UF] = 1'b1;
      fflags_o[rv_fcvt_pkg::FLAG_NX] = 1'b1;
    end else begin
      data_o = pack_fields(unp.sign, exp_biased[14:0], frac_out, op_fmt_i);
      fflags_o[rv_fcvt_pkg::FLAG_NX] = inexact;
    end
  end

endmodule

`default_nettype wire

/* src/rv_float_converter.sv */
`default_nettype none

module rv_float_converter #(
  parameter  bit DOUBLE    = 1,
  parameter  bit QUAD      = 1,
  localparam int REG_WIDTH = QUAD ? 128 : (DOUBLE ? 64 : 32)
) (
  input  logic [REG_WIDTH-1:0]  data_i,
  input  rv_fcvt_pkg::fmt_t     ip_fmt_i,
  input  rv_fcvt_pkg::fmt_t     op_fmt_i,
  output logic [REG_WIDTH-1:0]  data_o,
  output rv_fcvt_pkg::fflags_t  fflags_o
);

  // canonical single qnan for unsupported formats
  localparam logic [31:0] SINGLE_QNAN = 32'h7FC0_0000;

  // only nv for an unsupported format
  localparam rv_fcvt_pkg::fflags_t NAN_FLAGS =
    rv_fcvt_pkg::fflags_t'(1) << rv_fcvt_pkg::FLAG_NV;

  rv_fcvt_pkg::fp_word_t in_word;
  rv_fcvt_pkg::fp_word_t masked_data;
  rv_fcvt_pkg::fp_word_t packed_word;
  rv_fcvt_pkg::fflags_t  pack_flags;
  logic                  fmt_ok;

  // double and quad only exist when built in
  function automatic logic fmt_enabled(input rv_fcvt_pkg::fmt_t fmt);
    case (fmt)
      rv_fcvt_pkg::FMT_DOUBLE: fmt_enabled = DOUBLE;
      rv_fcvt_pkg::FMT_QUAD:   fmt_enabled = QUAD;
      default:                 fmt_enabled = 1'b1;
    endcase
  endfunction

  assign in_word = rv_fcvt_pkg::fp_word_t'(data_i);

  // keep only the bits of the input format
  always_comb begin
    case (ip_fmt_i)
      rv_fcvt_pkg::FMT_SINGLE: masked_data = in_word & {96'd0, {32{1'b1}}};
      rv_fcvt_pkg::FMT_DOUBLE: masked_data = in_word & {64'd0, {64{1'b1}}};
      rv_fcvt_pkg::FMT_HALF:   masked_data = in_word & {112'd0, {16{1'b1}}};
      default:                 masked_data = in_word;
    endcase
  end

  fp_unpacked_if unp_if ();

  fp_unpack u_unpack (
    .data_i   (masked_data),
    .ip_fmt_i (ip_fmt_i),
    .unp      (unp_if.producer)
  );

  fp_pack_round u_pack (
    .unp      (unp_if.consumer),
    .op_fmt_i (op_fmt_i),
    .data_o   (packed_word),
    .fflags_o (pack_flags)
  );

  assign fmt_ok = fmt_enabled(ip_fmt_i) & fmt_enabled(op_fmt_i);

  // upper bits of packed_word are already zero
  assign data_o   = fmt_ok ? packed_word[REG_WIDTH-1:0] : REG_WIDTH'(SINGLE_QNAN);
  assign fflags_o = fmt_ok ? pack_flags : NAN_FLAGS;

endmodule

`default_nettype wire

/* src/rv_fcvt_unit.sv */
`default_nettype none

module rv_fcvt_unit #(
  parameter  bit DOUBLE    = 1,
  parameter  bit QUAD      = 1,
  localparam int REG_WIDTH = QUAD ? 128 : (DOUBLE ? 64 : 32)
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  valid_i,
  input  rv_fcvt_pkg::fmt_t     ip_fmt_i,
  input  rv_fcvt_pkg::fmt_t     op_fmt_i,
  input  logic [REG_WIDTH-1:0]  data_i,
  output logic                  valid_o,
  output logic [REG_WIDTH-1:0]  data_o,
  output rv_fcvt_pkg::fflags_t  fflags_o
);

  // combinational converter result
  logic [REG_WIDTH-1:0] conv_data;
  rv_fcvt_pkg::fflags_t conv_flags;

  rv_float_converter #(
    .DOUBLE (DOUBLE),
    .QUAD   (QUAD)
  ) u_converter (
    .data_i   (data_i),
    .ip_fmt_i (ip_fmt_i),
    .op_fmt_i (op_fmt_i),
    .data_o   (conv_data),
    .fflags_o (conv_flags)
  );

  // one stage, result held while idle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o  <= 1'b0;
      data_o   <= '0;
      fflags_o <= '0;
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin
        data_o   <= conv_data;
        fflags_o <= conv_flags;
      end
    end
  end

  // first edge out of reset still shows no result
  a_no_valid_after_reset : assert property (
    @(posedge clk_i) $rose(rst_n_i) |-> !valid_o
  );

  // format conversion never divides
  a_dz_never_set : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) !fflags_o[rv_fcvt_pkg::FLAG_DZ]
  );

endmodule

`default_nettype wire

/* verif/rv_fcvt_tb.sv */
`default_nettype none

module rv_fcvt_tb;

  logic                 clk_i;
  logic                 rst_n_i;
  logic                 valid_i;
  rv_fcvt_pkg::fmt_t    ip_fmt_i;
  rv_fcvt_pkg::fmt_t    op_fmt_i;
  logic [127:0]         data_i;
  logic                 valid_o;
  logic [127:0]         data_o;
  rv_fcvt_pkg::fflags_t fflags_o;

  logic [31:0]          lfsr = 32'habe25a9a;
  // expected results pushed when valid_i is sampled
  logic [127:0]         exp_data_q [$];
  rv_fcvt_pkg::fflags_t exp_flags_q [$];

  rv_fcvt_unit #(.DOUBLE(1'b1), .QUAD(1'b1)) UUT (.*);

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  initial begin
    rst_n_i = 1'b0;
    repeat (8) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;
  end

  ////////////////////////////////////////////////////////////////////
  // error exits and compares
  ////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_data(input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp)
      abort_run($sformatf("mismatch at %0t: data_o %h, expected %h", $time, got, exp));
  endtask

  task automatic check_flags(input rv_fcvt_pkg::fflags_t got, input rv_fcvt_pkg::fflags_t exp);
    if (got !== exp)
      abort_run($sformatf("mismatch at %0t: fflags_o %b, expected %b", $time, got, exp));
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit
  task automatic take_bits(input int n, output logic [127:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[126:0], lfsr[0]};
    end
  endtask

  function automatic logic [127:0] build_fp(
    input rv_fcvt_pkg::fmt_t fmt,
    input logic              s,
    input int                e,
    input logic [127:0]      f
  );
    int mb;
    mb = rv_fcvt_pkg::MAN_BITS[fmt];
    build_fp = (128'(s) << (rv_fcvt_pkg::EXP_BITS[fmt] + mb))
             | (128'(e) << mb)
             | (f & ((128'(1) << mb) - 128'(1)));
  endfunction

  function automatic bit narrows(input rv_fcvt_pkg::fmt_t ip, input rv_fcvt_pkg::fmt_t op);
    narrows = rv_fcvt_pkg::MAN_BITS[op] < rv_fcvt_pkg::MAN_BITS[ip];
  endfunction

  ////////////////////////////////////////////////////////////////////
  // reference conversion from the input fields
  ////////////////////////////////////////////////////////////////////

  function automatic void ref_convert(
    input  rv_fcvt_pkg::fmt_t    ip,
    input  rv_fcvt_pkg::fmt_t    op,
    input  logic [127:0]         d,
    output logic [127:0]         res,
    output rv_fcvt_pkg::fflags_t fl
  );
    int           eb_i;
    int           mb_i;
    int           mb_o;
    int           sh;
    int           e;
    int           eo;
    logic         s;
    logic [127:0] f;
    logic [127:0] fo;
    logic [127:0] rem;
    logic [127:0] half;
    eb_i = rv_fcvt_pkg::EXP_BITS[ip];
    mb_i = rv_fcvt_pkg::MAN_BITS[ip];
    mb_o = rv_fcvt_pkg::MAN_BITS[op];
    // bits above the input format are ignored
    s  = ((d >> (eb_i + mb_i)) & 128'(1)) != '0;
    e  = int'((d >> mb_i) & ((128'(1) << eb_i) - 128'(1)));
    f  = d & ((128'(1) << mb_i) - 128'(1));
    fl = '0;
    fo = '0;
    // all ones exponent of the target
    eo = (1 << rv_fcvt_pkg::EXP_BITS[op]) - 1;
    if (e == (1 << eb_i) - 1) begin
      if (f != '0) begin
        // canonical qnan with nv only for a signalling input
        s  = 1'b0;
        fo = 128'(1) << (mb_o - 1);
        fl[rv_fcvt_pkg::FLAG_NV] = (f >> (mb_i - 1)) == '0;
      end
    end else if (e == 0) begin
      eo = 0;
    end else begin
      e = e - rv_fcvt_pkg::BIAS[ip] + rv_fcvt_pkg::BIAS[op];
      if (mb_o >= mb_i) begin
        fo = f << (mb_o - mb_i);
      end else begin
        sh   = mb_i - mb_o;
        fo   = f >> sh;
        rem  = f & ((128'(1) << sh) - 128'(1));
        half = 128'(1) << (sh - 1);
        fl[rv_fcvt_pkg::FLAG_NX] = rem != '0;
        // round to nearest with ties to even
        if (rem > half || (rem == half && fo[0]))
          fo = fo + 128'(1);
        if ((fo >> mb_o) != '0) begin
          fo = '0;
          e  = e + 1;
        end
      end
      if (e >= eo) begin
        fo = '0;
        fl[rv_fcvt_pkg::FLAG_OF] = 1'b1;
        fl[rv_fcvt_pkg::FLAG_NX] = 1'b1;
      end else if (e <= 0) begin
        fo = '0;
        eo = 0;
        fl[rv_fcvt_pkg::FLAG_UF] = 1'b1;
        fl[rv_fcvt_pkg::FLAG_NX] = 1'b1;
      end else begin
        eo = e;
      end
    end
    res = build_fp(op, s, eo, fo);
  endfunction

  ////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////

  // kind 0 any normal, 1 in target range, 2 tie, 3 overflow, 4 underflow, 5 special
  task automatic random_operand(
    input  rv_fcvt_pkg::fmt_t ip,
    input  rv_fcvt_pkg::fmt_t op,
    input  int                kind,
    output logic [127:0]      v
  );
    logic [127:0] r;
    logic [127:0] f;
    logic [127:0] junk;
    int           mb;
    int           sh;
    int           bi;
    int           bo;
    int           e;
    mb = rv_fcvt_pkg::MAN_BITS[ip];
    sh = mb - rv_fcvt_pkg::MAN_BITS[op];
    bi = rv_fcvt_pkg::BIAS[ip];
    bo = rv_fcvt_pkg::BIAS[op];
    take_bits(mb, f);
    take_bits(17, r);
    take_bits(32, junk);
    e = bi - bo + 1 + int'(r[15:0]) % (2 * bo);
    case (kind)
      0: e = 1 + int'(r[15:0]) % (2 * bi);
      // exact tie where the kept lsb picks the direction
      2: f = ((f >> sh) << sh) | (128'(1) << (sh - 1));
      3: e = bi + bo + 1 + int'(r[1:0]);
      4: e = bi - bo - int'(r[1:0]);
      5: begin
        e = 2 * bi + 1;
        case (r[2:0])
          3'd0: begin
            e = 0;
            f = '0;
          end
          3'd1: begin
            // subnormal
            e = 0;
            f = f | 128'(1);
          end
          3'd2: f = '0;
          3'd3: f = f | (128'(1) << (mb - 1));
          default: f = (f & ~(128'(1) << (mb - 1))) | 128'(1);
        endcase
      end
      default: ;
    endcase
    // garbage above the format that the DUT masks off
    v = build_fp(ip, r[16], e, f) | (junk << (rv_fcvt_pkg::EXP_BITS[ip] + mb + 1));
  endtask

  task automatic send(
    input rv_fcvt_pkg::fmt_t ip,
    input rv_fcvt_pkg::fmt_t op,
    input logic [127:0]      v
  );
    @(posedge clk_i);
    #2;
    valid_i  = 1'b1;
    ip_fmt_i = ip;
    op_fmt_i = op;
    data_i   = v;
  endtask

  task automatic idle();
    @(posedge clk_i);
    #2;
    valid_i = 1'b0;
  endtask

  // outputs and inputs both settled mid cycle
  always @(negedge clk_i) begin
    logic [127:0]         exp_d;
    rv_fcvt_pkg::fflags_t exp_f;
    if (rst_n_i) begin
      if (exp_data_q.size() != 0) begin
        if (valid_o !== 1'b1)
          abort_run("valid_o stayed low when a result was due");
        check_data(data_o, exp_data_q.pop_front());
        check_flags(fflags_o, exp_flags_q.pop_front());
      end else if (valid_o !== 1'b0) begin
        abort_run("valid_o went high without a matching input");
      end
      if (valid_i) begin
        ref_convert(ip_fmt_i, op_fmt_i, data_i, exp_d, exp_f);
        exp_data_q.push_back(exp_d);
        exp_flags_q.push_back(exp_f);
      end
    end
  end

  // cycle limit for the whole run
  initial begin
    for (int i = 0; i < 4000; i++)
      @(posedge clk_i);
    abort_run("simulation did not finish within the cycle limit");
  end

  initial begin
    int                n;
    int                kind;
    logic [127:0]      v;
    logic [127:0]      r;
    rv_fcvt_pkg::fmt_t ip;
    rv_fcvt_pkg::fmt_t op;
    valid_i   = 1'b0;
    ip_fmt_i  = rv_fcvt_pkg::FMT_SINGLE;
    op_fmt_i  = rv_fcvt_pkg::FMT_SINGLE;
    data_i    = '0;
    n         = 0;
    while (rst_n_i !== 1'b1) begin
      @(posedge clk_i);
      n++;
      if (n > 20)
        abort_run("reset was never released");
    end
    #2;
    if (valid_o !== 1'b0)
      abort_run("valid_o is high right after reset");
    check_flags(fflags_o, '0);

    // exact widening and same format
    for (int a = 0; a < 4; a++) begin
      for (int b = 0; b < 4; b++) begin
        ip = rv_fcvt_pkg::fmt_t'(a);
        op = rv_fcvt_pkg::fmt_t'(b);
        if (!narrows(ip, op)) begin
          repeat (20) begin
            random_operand(ip, op, 0, v);
            send(ip, op, v);
          end
        end
      end
    end
    idle();

    // narrowing plus specials on every pair
    for (int a = 0; a < 4; a++) begin
      for (int b = 0; b < 4; b++) begin
        ip = rv_fcvt_pkg::fmt_t'(a);
        op = rv_fcvt_pkg::fmt_t'(b);
        for (int k = 1; k <= 5; k++) begin
          if (narrows(ip, op) || k == 5) begin
            repeat (12) begin
              random_operand(ip, op, k, v);
              send(ip, op, v);
            end
          end
        end
      end
    end
    idle();

    // 200 back to back for one result per cycle
    for (int i = 0; i < 200; i++) begin
      take_bits(4, r);
      ip   = rv_fcvt_pkg::fmt_t'(r[1:0]);
      op   = rv_fcvt_pkg::fmt_t'(r[3:2]);
      kind = narrows(ip, op) ? (i % 6) : ((i % 2 == 0) ? 0 : 5);
      random_operand(ip, op, kind, v);
      send(ip, op, v);
    end
    idle();

    n = 0;
    while (exp_data_q.size() != 0 && n <= 8) begin
      @(posedge clk_i);
      n++;
    end
    if (exp_data_q.size() != 0) begin
      abort_run("results still pending after the last input");
    end else begin
      $display("Simulation passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* rv_fcvt.f */
src/rv_fcvt_pkg.sv
src/fp_unpacked_if.sv
src/fp_unpack.sv
src/fp_pack_round.sv
src/rv_float_converter.sv
src/rv_fcvt_unit.sv
verif/rv_fcvt_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 \
  --top-module rv_fcvt_tb \
  -f rv_fcvt.f \
  -o rv_fcvt_sim
./obj_dir/rv_fcvt_sim
